// File: Bender.yml
package:
  name: rv64i_core

sources:
  - rv_isa_pkg.sv
  - core_bus_pkg.sv
  - bus_arbiter.sv
  - fetch_unit.sv
  - load_store_unit.sv
  - issue_exec.sv
  - core_top.sv
  - target: simulation
    files:
      - tb_core_top.sv

// File: build.f
rv_isa_pkg.sv
core_bus_pkg.sv
bus_arbiter.sv
fetch_unit.sv
load_store_unit.sv
issue_exec.sv
core_top.sv
tb_core_top.sv

// File: bus_arbiter.sv
// memory port arbiter: lsu-first grant, credit tracking and in-order response routing
`timescale 1ns/1ps

module bus_arbiter (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            if_req,
	input  logic [core_bus_pkg::addr_w-1:0] if_addr,
	output logic                            if_gnt,
	output logic                            if_rsp_valid,
	input  logic                            ls_req,
	input  logic [core_bus_pkg::addr_w-1:0] ls_addr,
	input  logic                            ls_write,
	input  logic [rv_isa_pkg::xlen-1:0]     ls_wdata,
	input  logic [core_bus_pkg::strb_w-1:0] ls_strb,
	output logic                            ls_gnt,
	output logic                            ls_rsp_valid,
	output logic [rv_isa_pkg::xlen-1:0]     rsp_rdata,
	output logic                            mem_req_valid,
	output logic [core_bus_pkg::addr_w-1:0] mem_req_addr,
	output logic                            mem_req_write,
	output logic [rv_isa_pkg::xlen-1:0]     mem_req_wdata,
	output logic [core_bus_pkg::strb_w-1:0] mem_req_strb,
	input  logic                            mem_credit,
	input  logic                            mem_rsp_valid,
	input  logic [rv_isa_pkg::xlen-1:0]     mem_rsp_rdata
);

	logic [core_bus_pkg::cnt_w-1:0]           credits;
	logic [core_bus_pkg::max_outstanding-1:0] owner;
	logic [core_bus_pkg::ptr_w-1:0]           wr_ptr;
	logic [core_bus_pkg::ptr_w-1:0]           rd_ptr;
	logic [core_bus_pkg::occ_w-1:0]           occ;
	logic                                     can_send;

	// ********************************************************************
	// grant, lsu wins a tie
	// ********************************************************************
	assign can_send = (credits != '0) && (occ != core_bus_pkg::occ_full);
	assign ls_gnt = ls_req && can_send;
	assign if_gnt = if_req && can_send && !ls_req;

	assign mem_req_valid = ls_gnt || if_gnt;
	assign mem_req_addr  = ls_gnt ? ls_addr : if_addr;
	assign mem_req_write = ls_gnt && ls_write;
	assign mem_req_wdata = ls_wdata;
	// instruction reads carry no strobe
	assign mem_req_strb  = ls_gnt ? ls_strb : '0;

	// responses come back in order, head of the fifo names the owner
	assign if_rsp_valid = mem_rsp_valid && (owner[rd_ptr] == core_bus_pkg::req_fetch);
	assign ls_rsp_valid = mem_rsp_valid && (owner[rd_ptr] == core_bus_pkg::req_lsu);
	assign rsp_rdata    = mem_rsp_rdata;

	// credit count and fifo pointers
	always_ff @(posedge clk) begin
		if (rst) begin
			credits <= core_bus_pkg::credit_max;
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			occ     <= '0;
		end else begin
			case ({mem_req_valid, mem_credit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
			if (mem_req_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (mem_rsp_valid)
				rd_ptr <= rd_ptr + 1'b1;
			case ({mem_req_valid, mem_rsp_valid})
				2'b10:   occ <= occ + 1'b1;
				2'b01:   occ <= occ - 1'b1;
				default: occ <= occ;
			endcase
		end
	end

	// owner entries
	always_ff @(posedge clk) begin
		if (mem_req_valid)
			owner[wr_ptr] <= ls_gnt ? core_bus_pkg::req_lsu : core_bus_pkg::req_fetch;
	end

	// memory never hands back more slots than it owns
	a_credit_bound: assert property (@(posedge clk) disable iff (rst)
		credits <= core_bus_pkg::credit_max);

	// every response matches a request still tracked
	a_rsp_tracked: assert property (@(posedge clk) disable iff (rst)
		mem_rsp_valid |-> (occ != '0));

endmodule

// File: core_bus_pkg.sv
// shared memory port definitions: widths, flow-control limits, owner codes and lsu states
package core_bus_pkg;

	// port widths
	localparam int addr_w = 32;
	localparam int strb_w = 8;

	// credit counter, starts full
	localparam int mem_credits = 2;
	localparam int cnt_w = $clog2(mem_credits + 1);
	localparam logic [cnt_w-1:0] credit_max = mem_credits[cnt_w-1:0];

	// owner fifo geometry
	localparam int max_outstanding = 4;
	localparam int ptr_w = $clog2(max_outstanding);
	localparam int occ_w = ptr_w + 1;
	localparam logic [occ_w-1:0] occ_full = max_outstanding[occ_w-1:0];

	// requester codes stored per outstanding request
	localparam logic req_fetch = 1'b0;
	localparam logic req_lsu   = 1'b1;

	// load/store unit bus phases
	localparam logic [1:0] ls_idle    = 2'd0;
	localparam logic [1:0] ls_request = 2'd1;
	localparam logic [1:0] ls_wait    = 2'd2;

endpackage

// File: core_top.sv
// rv64i core top: fetch, issue/execute and load/store behind one arbitrated memory port
`timescale 1ns/1ps

module core_top (
	input  logic                            clk,
	input  logic                            rst,
	output logic                            mem_req_valid,
	output logic [core_bus_pkg::addr_w-1:0] mem_req_addr,
	output logic                            mem_req_write,
	output logic [rv_isa_pkg::xlen-1:0]     mem_req_wdata,
	output logic [core_bus_pkg::strb_w-1:0] mem_req_strb,
	input  logic                            mem_credit,
	input  logic                            mem_rsp_valid,
	input  logic [rv_isa_pkg::xlen-1:0]     mem_rsp_rdata,
	output logic                            retire_valid,
	output logic [4:0]                      retire_rd,
	output logic [rv_isa_pkg::xlen-1:0]     retire_value,
	output logic                            halted
);

	// fetch side of the arbiter
	logic                            if_req;
	logic [core_bus_pkg::addr_w-1:0] if_addr;
	logic                            if_gnt;
	logic                            if_rsp_valid;
	logic [rv_isa_pkg::xlen-1:0]     rsp_rdata;

	// lsu side of the arbiter
	logic                            ls_req;
	logic [core_bus_pkg::addr_w-1:0] ls_bus_addr;
	logic                            ls_write;
	logic [rv_isa_pkg::xlen-1:0]     ls_bus_wdata;
	logic [core_bus_pkg::strb_w-1:0] ls_strb;
	logic                            ls_gnt;
	logic                            ls_rsp_valid;

	// fetch to issue
	logic                            fe_valid;
	logic                            fe_ready;
	logic [rv_isa_pkg::xlen-1:0]     fe_pc;
	logic [rv_isa_pkg::ilen-1:0]     fe_insn;
	logic                            redirect;
	logic [rv_isa_pkg::xlen-1:0]     redirect_pc;

	// issue to lsu and writeback
	logic                            ls_valid;
	logic                            ls_ready;
	logic                            ls_is_store;
	logic [core_bus_pkg::addr_w-1:0] ls_addr;
	logic [rv_isa_pkg::xlen-1:0]     ls_wdata;
	logic [4:0]                      ls_rd;
	logic                            wb_valid;
	logic [4:0]                      wb_rd;
	logic [rv_isa_pkg::xlen-1:0]     wb_data;

	// arbiter sees the lsu bus-side address and data
	bus_arbiter i_bus_arbiter (
		.ls_addr  (ls_bus_addr),
		.ls_wdata (ls_bus_wdata),
		.*
	);

	fetch_unit i_fetch_unit (
		.halt (halted),
		.*
	);

	load_store_unit i_load_store_unit (
		.*
	);

	issue_exec i_issue_exec (
		.halt (halted),
		.*
	);

endmodule

// File: fetch_unit.sv
// instruction fetch with the pc, one outstanding read, redirect squash and a one-entry hold
`timescale 1ns/1ps

module fetch_unit (
	input  logic                            clk,
	input  logic                            rst,
	output logic                            if_req,
	output logic [core_bus_pkg::addr_w-1:0] if_addr,
	input  logic                            if_gnt,
	input  logic                            if_rsp_valid,
	input  logic [rv_isa_pkg::xlen-1:0]     rsp_rdata,
	output logic                            fe_valid,
	input  logic                            fe_ready,
	output logic [rv_isa_pkg::xlen-1:0]     fe_pc,
	output logic [rv_isa_pkg::ilen-1:0]     fe_insn,
	input  logic                            redirect,
	input  logic [rv_isa_pkg::xlen-1:0]     redirect_pc,
	input  logic                            halt
);

	logic [rv_isa_pkg::xlen-1:0] pc;
	logic                        fetch_en;
	logic                        inflight;
	logic                        epoch;
	logic                        req_epoch;
	logic                        rsp_keep;

	// fetch_en low in reset and for good once halted
	assign if_req  = fetch_en && !halt && !inflight && !fe_valid && !redirect;
	assign if_addr = {pc[core_bus_pkg::addr_w-1:3], 3'b000};
	assign fe_pc   = pc;

	// stale epoch or a redirect in the same cycle drops the word
	assign rsp_keep = if_rsp_valid && (req_epoch == epoch) && !redirect;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc       <= '0;
			fetch_en <= 1'b0;
			inflight <= 1'b0;
			epoch    <= 1'b0;
			fe_valid <= 1'b0;
		end else begin
			fetch_en <= !halt;
			if (if_gnt)
				inflight <= 1'b1;
			else if (if_rsp_valid)
				inflight <= 1'b0;
			if (redirect) begin
				pc       <= redirect_pc;
				epoch    <= !epoch;
				fe_valid <= 1'b0;
			end else if (fe_valid && fe_ready) begin
				pc       <= pc + rv_isa_pkg::xlen'(4);
				fe_valid <= 1'b0;
			end else if (rsp_keep) begin
				fe_valid <= 1'b1;
			end
		end
	end

	// request epoch and held word with pc bit 2 picking the half
	always_ff @(posedge clk) begin
		if (if_gnt)
			req_epoch <= epoch;
		if (rsp_keep)
			fe_insn <= pc[2] ? rsp_rdata[rv_isa_pkg::xlen-1:rv_isa_pkg::ilen]
				: rsp_rdata[rv_isa_pkg::ilen-1:0];
	end

endmodule

// File: issue_exec.sv
// issue and execute: decode, register file, busy scoreboard, alu, branches and retire
`timescale 1ns/1ps

module issue_exec (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            fe_valid,
	output logic                            fe_ready,
	input  logic [rv_isa_pkg::xlen-1:0]     fe_pc,
	input  logic [rv_isa_pkg::ilen-1:0]     fe_insn,
	output logic                            redirect,
	output logic [rv_isa_pkg::xlen-1:0]     redirect_pc,
	output logic                            ls_valid,
	input  logic                            ls_ready,
	output logic                            ls_is_store,
	output logic [core_bus_pkg::addr_w-1:0] ls_addr,
	output logic [rv_isa_pkg::xlen-1:0]     ls_wdata,
	output logic [4:0]                      ls_rd,
	input  logic                            wb_valid,
	input  logic [4:0]                      wb_rd,
	input  logic [rv_isa_pkg::xlen-1:0]     wb_data,
	output logic                            retire_valid,
	output logic [4:0]                      retire_rd,
	output logic [rv_isa_pkg::xlen-1:0]     retire_value,
	output logic                            halt
);

	rv_isa_pkg::insn_word_t      insn;
	logic [6:0]                  opc;
	logic [4:0]                  rs1;
	logic [4:0]                  rs2;
	logic [4:0]                  rd;
	logic                        is_addi;
	logic                        is_add;
	logic                        is_sub;
	logic                        is_lui;
	logic                        is_ld;
	logic                        is_sd;
	logic                        is_beq;
	logic                        is_jal;
	logic                        is_halt;
	logic                        uses_rs1;
	logic                        uses_rs2;
	logic                        writes_rd;
	logic                        alu_wr;
	logic                        hazard;
	logic                        fire;
	logic                        take;
	logic [rv_isa_pkg::xlen-1:0] imm_i;
	logic [rv_isa_pkg::xlen-1:0] imm_s;
	logic [rv_isa_pkg::xlen-1:0] imm_b;
	logic [rv_isa_pkg::xlen-1:0] imm_u;
	logic [rv_isa_pkg::xlen-1:0] imm_j;
	logic [rv_isa_pkg::xlen-1:0] rs1_val;
	logic [rv_isa_pkg::xlen-1:0] rs2_val;
	logic [rv_isa_pkg::xlen-1:0] mem_ea;
	logic [rv_isa_pkg::xlen-1:0] alu_out;
	logic [rv_isa_pkg::xlen-1:0] rf [1:31];
	logic [31:0]                 busy;

	// ********************************************************************
	// decode, rs2 only exists in the s/b view
	// ********************************************************************
	assign insn = fe_insn;
	assign opc  = insn.i.opcode;
	assign rs1  = insn.i.rs1;
	assign rs2  = insn.sb.rs2;
	assign rd   = insn.i.rd;

	assign is_addi = (opc == rv_isa_pkg::op_imm) && (insn.i.funct3 == rv_isa_pkg::f3_add);
	assign is_add  = (opc == rv_isa_pkg::op) && (insn.i.funct3 == rv_isa_pkg::f3_add)
		&& (insn.i.imm[11:5] == rv_isa_pkg::f7_add);
	assign is_sub  = (opc == rv_isa_pkg::op) && (insn.i.funct3 == rv_isa_pkg::f3_add)
		&& (insn.i.imm[11:5] == rv_isa_pkg::f7_sub);
	assign is_lui  = (opc == rv_isa_pkg::lui);
	assign is_ld   = (opc == rv_isa_pkg::load) && (insn.i.funct3 == rv_isa_pkg::f3_dword);
	assign is_sd   = (opc == rv_isa_pkg::store) && (insn.sb.funct3 == rv_isa_pkg::f3_dword);
	assign is_beq  = (opc == rv_isa_pkg::branch) && (insn.sb.funct3 == rv_isa_pkg::f3_beq);
	assign is_jal  = (opc == rv_isa_pkg::jal);
	// ebreak, and anything not listed above behaves like it
	assign is_halt = (opc == rv_isa_pkg::system)
		|| !(is_addi || is_add || is_sub || is_lui || is_ld || is_sd || is_beq || is_jal);

	// sign-extended immediates
	assign imm_i = {{(rv_isa_pkg::xlen-12){insn.i.imm[11]}}, insn.i.imm};
	assign imm_s = {{(rv_isa_pkg::xlen-12){insn.sb.imm_hi[6]}}, insn.sb.imm_hi, insn.sb.imm_lo};
	assign imm_b = {{(rv_isa_pkg::xlen-12){insn.sb.imm_hi[6]}}, insn.sb.imm_lo[0],
		insn.sb.imm_hi[5:0], insn.sb.imm_lo[4:1], 1'b0};
	assign imm_u = {{(rv_isa_pkg::xlen-32){fe_insn[31]}}, fe_insn[31:12], 12'b0};
	assign imm_j = {{(rv_isa_pkg::xlen-20){fe_insn[31]}}, fe_insn[19:12], fe_insn[20],
		fe_insn[30:21], 1'b0};

	// x0 reads as zero
	assign rs1_val = (rs1 == 5'd0) ? '0 : rf[rs1];
	assign rs2_val = (rs2 == 5'd0) ? '0 : rf[rs2];

	// ********************************************************************
	// scoreboard and issue
	// ********************************************************************
	assign uses_rs1  = is_addi || is_add || is_sub || is_ld || is_sd || is_beq;
	assign uses_rs2  = is_add || is_sub || is_sd || is_beq;
	assign writes_rd = (is_addi || is_add || is_sub || is_lui || is_ld || is_jal) && (rd != 5'd0);
	assign alu_wr    = writes_rd && !is_ld;
	assign hazard    = (uses_rs1 && busy[rs1]) || (uses_rs2 && busy[rs2]) || (writes_rd && busy[rd]);

	// load writeback owns the write port, lsu takes one access at a time
	assign fe_ready = !halt && !redirect && !hazard && !(alu_wr && wb_valid)
		&& !((is_ld || is_sd) && !ls_ready);
	assign fire = fe_valid && fe_ready;
	assign take = is_jal || (is_beq && (rs1_val == rs2_val));

	always_comb begin
		if (is_lui)
			alu_out = imm_u;
		else if (is_jal)
			alu_out = fe_pc + rv_isa_pkg::xlen'(4);
		else if (is_sub)
			alu_out = rs1_val - rs2_val;
		else if (is_add)
			alu_out = rs1_val + rs2_val;
		else
			alu_out = rs1_val + imm_i;
	end

	// memory op goes to the lsu in the transfer cycle
	assign mem_ea      = rs1_val + (is_sd ? imm_s : imm_i);
	assign ls_valid    = fire && (is_ld || is_sd);
	assign ls_is_store = is_sd;
	assign ls_addr     = mem_ea[core_bus_pkg::addr_w-1:0];
	assign ls_wdata    = rs2_val;
	assign ls_rd       = rd;

	// single write port
	always_ff @(posedge clk) begin
		if (wb_valid && (wb_rd != 5'd0))
			rf[wb_rd] <= wb_data;
		else if (fire && alu_wr)
			rf[rd] <= alu_out;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy         <= '0;
			retire_valid <= 1'b0;
			redirect     <= 1'b0;
			halt         <= 1'b0;
		end else begin
			if (wb_valid)
				busy[wb_rd] <= 1'b0;
			if (fire && is_ld && writes_rd)
				busy[rd] <= 1'b1;
			retire_valid <= (wb_valid && (wb_rd != 5'd0)) || (fire && alu_wr);
			redirect     <= fire && take;
			if (fire && is_halt)
				halt <= 1'b1;
		end
	end

	// retire payload and branch target
	always_ff @(posedge clk) begin
		if (wb_valid) begin
			retire_rd    <= wb_rd;
			retire_value <= wb_data;
		end else begin
			retire_rd    <= rd;
			retire_value <= alu_out;
		end
		redirect_pc <= fe_pc + (is_jal ? imm_j : imm_b);
	end

	// load data only lands on a register the scoreboard holds
	a_wb_busy: assert property (@(posedge clk) disable iff (rst)
		wb_valid |-> ((wb_rd == 5'd0) || busy[wb_rd]));

endmodule

// File: load_store_unit.sv
// load/store unit: one 64-bit LD or SD at a time on the shared bus, load writeback
`timescale 1ns/1ps

module load_store_unit (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            ls_valid,
	output logic                            ls_ready,
	input  logic                            ls_is_store,
	input  logic [core_bus_pkg::addr_w-1:0] ls_addr,
	input  logic [rv_isa_pkg::xlen-1:0]     ls_wdata,
	input  logic [4:0]                      ls_rd,
	output logic                            ls_req,
	output logic [core_bus_pkg::addr_w-1:0] ls_bus_addr,
	output logic                            ls_write,
	output logic [rv_isa_pkg::xlen-1:0]     ls_bus_wdata,
	output logic [core_bus_pkg::strb_w-1:0] ls_strb,
	input  logic                            ls_gnt,
	input  logic                            ls_rsp_valid,
	input  logic [rv_isa_pkg::xlen-1:0]     rsp_rdata,
	output logic                            wb_valid,
	output logic [4:0]                      wb_rd,
	output logic [rv_isa_pkg::xlen-1:0]     wb_data
);

	logic [1:0]                      state;
	logic                            is_store;
	logic [core_bus_pkg::addr_w-1:0] addr_q;
	logic [rv_isa_pkg::xlen-1:0]     wdata_q;
	logic [4:0]                      rd_q;

	assign ls_ready = (state == core_bus_pkg::ls_idle);
	assign ls_req   = (state == core_bus_pkg::ls_request);

	// doubleword only, so aligned address and full strobe
	assign ls_bus_addr  = {addr_q[core_bus_pkg::addr_w-1:3], 3'b000};
	assign ls_write     = is_store;
	assign ls_bus_wdata = wdata_q;
	assign ls_strb      = '1;

	// store response just closes the access
	assign wb_valid = (state == core_bus_pkg::ls_wait) && ls_rsp_valid && !is_store;
	assign wb_rd    = rd_q;
	assign wb_data  = rsp_rdata;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= core_bus_pkg::ls_idle;
		end else begin
			case (state)
				core_bus_pkg::ls_idle:
					if (ls_valid)
						state <= core_bus_pkg::ls_request;
				core_bus_pkg::ls_request:
					if (ls_gnt)
						state <= core_bus_pkg::ls_wait;
				core_bus_pkg::ls_wait:
					if (ls_rsp_valid)
						state <= core_bus_pkg::ls_idle;
				default:
					state <= core_bus_pkg::ls_idle;
			endcase
		end
	end

	// access captured at acceptance
	always_ff @(posedge clk) begin
		if (ls_valid && ls_ready) begin
			is_store <= ls_is_store;
			addr_q   <= ls_addr;
			wdata_q  <= ls_wdata;
			rd_q     <= ls_rd;
		end
	end

endmodule

// File: rv_isa_pkg.sv
// rv64i instruction set definitions: widths, opcodes and the two-view instruction word
package rv_isa_pkg;

	// data and instruction widths
	localparam int xlen = 64;
	localparam int ilen = 32;

	// major opcodes, bits [6:0]
	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op     = 7'b0110011;
	localparam logic [6:0] lui    = 7'b0110111;
	localparam logic [6:0] load   = 7'b0000011;
	localparam logic [6:0] store  = 7'b0100011;
	localparam logic [6:0] branch = 7'b1100011;
	localparam logic [6:0] jal    = 7'b1101111;
	localparam logic [6:0] system = 7'b1110011;

	// funct3 values the core accepts
	localparam logic [2:0] f3_add   = 3'b000;
	localparam logic [2:0] f3_dword = 3'b011;
	localparam logic [2:0] f3_beq   = 3'b000;

	// funct7 of sub, upper seven bits of the i-format immediate
	localparam logic [6:0] f7_add = 7'b0000000;
	localparam logic [6:0] f7_sub = 7'b0100000;

	// i-format view, also covers r-format funct7 in imm[11:5]
	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	// s and b format view, immediate split around rs2/rs1
	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} sb_fmt_t;

	// one instruction word, two decodings
	typedef union packed {
		i_fmt_t  i;
		sb_fmt_t sb;
	} insn_word_t;

endpackage

// File: tb_core_top.sv
// testbench for the rv64i core with a program table, a random-latency credit memory and retire checks
`timescale 1ns/1ps

module tb_core_top;

	logic                            clk;
	logic                            rst;
	logic                            mem_req_valid;
	logic [core_bus_pkg::addr_w-1:0] mem_req_addr;
	logic                            mem_req_write;
	logic [rv_isa_pkg::xlen-1:0]     mem_req_wdata;
	logic [core_bus_pkg::strb_w-1:0] mem_req_strb;
	logic                            mem_credit;
	logic                            mem_rsp_valid;
	logic [rv_isa_pkg::xlen-1:0]     mem_rsp_rdata;
	logic                            retire_valid;
	logic [4:0]                      retire_rd;
	logic [rv_isa_pkg::xlen-1:0]     retire_value;
	logic                            halted;

	// program table with one row per instruction
	rv_isa_pkg::insn_word_t      row_insn [$];
	logic [4:0]                  row_rd [$];
	logic [rv_isa_pkg::xlen-1:0] row_val [$];
	bit                          row_wr [$];

	// expected writes and retire bookkeeping indexed by rd
	bit                          exp_wr [32];
	logic [rv_isa_pkg::xlen-1:0] exp_val [32];
	bit                          seen [32];
	int                          ret_cyc [32];

	// memory model state
	logic [rv_isa_pkg::xlen-1:0] mem [0:63];
	logic [rv_isa_pkg::xlen-1:0] rsp_data_q [$];
	int                          rsp_due_q [$];
	int                          tb_credits;
	int                          credit_pend;
	int                          cyc;
	bit                          halt_seen;
	logic [31:0]                 lfsr;

	core_top i_core_top (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ********************************************************************
	// random source and instruction encoders
	// ********************************************************************
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		else
			return s >> 1;
	endfunction

	// one lfsr step per bit taken
	function automatic int draw(input int n);
		int r;
		int k;
		r = 0;
		for (k = 0; k < n; k++) begin
			r = (r << 1) | int'(lfsr[0]);
			lfsr = lfsr_step(lfsr);
		end
		return r;
	endfunction

	function automatic logic [63:0] sext12(input logic [11:0] v);
		return {{52{v[11]}}, v};
	endfunction

	function automatic logic [63:0] sext32(input logic [31:0] v);
		return {{32{v[31]}}, v};
	endfunction

	function automatic rv_isa_pkg::insn_word_t imm_form(input logic [6:0] opc,
		input logic [4:0] rd, input logic [2:0] f3, input logic [4:0] rs1,
		input logic [11:0] imm);
		rv_isa_pkg::insn_word_t w;
		w.i.imm    = imm;
		w.i.rs1    = rs1;
		w.i.funct3 = f3;
		w.i.rd     = rd;
		w.i.opcode = opc;
		return w;
	endfunction

	// r-format keeps funct7 and rs2 in the i-format immediate
	function automatic rv_isa_pkg::insn_word_t reg_form(input logic [6:0] f7,
		input logic [4:0] rs2, input logic [4:0] rs1, input logic [4:0] rd);
		return imm_form(rv_isa_pkg::op, rd, rv_isa_pkg::f3_add, rs1, {f7, rs2});
	endfunction

	function automatic rv_isa_pkg::insn_word_t store_form(input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [11:0] imm);
		rv_isa_pkg::insn_word_t w;
		w.sb.imm_hi = imm[11:5];
		w.sb.rs2    = rs2;
		w.sb.rs1    = rs1;
		w.sb.funct3 = rv_isa_pkg::f3_dword;
		w.sb.imm_lo = imm[4:0];
		w.sb.opcode = rv_isa_pkg::store;
		return w;
	endfunction

	// beq with byte offset bits 12:1
	function automatic rv_isa_pkg::insn_word_t branch_form(input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [12:0] off);
		rv_isa_pkg::insn_word_t w;
		w.sb.imm_hi = {off[12], off[10:5]};
		w.sb.rs2    = rs2;
		w.sb.rs1    = rs1;
		w.sb.funct3 = rv_isa_pkg::f3_beq;
		w.sb.imm_lo = {off[4:1], off[11]};
		w.sb.opcode = rv_isa_pkg::branch;
		return w;
	endfunction

	function automatic rv_isa_pkg::insn_word_t upper_form(input logic [4:0] rd,
		input logic [19:0] imm);
		return {imm, rd, rv_isa_pkg::lui};
	endfunction

	function automatic rv_isa_pkg::insn_word_t jump_form(input logic [4:0] rd,
		input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, rv_isa_pkg::jal};
	endfunction

	// ********************************************************************
	// checks
	// ********************************************************************
	task automatic check_reg(input string name, input logic [4:0] rd,
		input logic [rv_isa_pkg::xlen-1:0] exp_value,
		input logic [rv_isa_pkg::xlen-1:0] act_value);
		if (exp_value !== act_value) begin
			$display("[FAIL] %s rd x%0d expected %h actual %h", name, rd, exp_value, act_value);
			$display("Simulation FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_flag(input string name, input logic exp_flag, input logic act_flag);
		if (exp_flag !== act_flag) begin
			$display("[FAIL] %s expected %0b actual %0b", name, exp_flag, act_flag);
			$display("Simulation FAILED");
			$fatal(1);
		end
	endtask

	// ********************************************************************
	// program and expected values
	// ********************************************************************
	task automatic add_row(input rv_isa_pkg::insn_word_t insn, input logic [4:0] rd,
		input logic [rv_isa_pkg::xlen-1:0] val, input bit wr);
		row_insn.push_back(insn);
		row_rd.push_back(rd);
		row_val.push_back(val);
		row_wr.push_back(wr);
	endtask

	task automatic build_program();
		logic [rv_isa_pkg::xlen-1:0] xv [32];
		xv[1] = sext12(12'd100);
		add_row(imm_form(rv_isa_pkg::op_imm, 5'd1, rv_isa_pkg::f3_add, 5'd0, 12'd100), 1, xv[1], 1);
		xv[2] = sext12(12'hff9);
		add_row(imm_form(rv_isa_pkg::op_imm, 5'd2, rv_isa_pkg::f3_add, 5'd0, 12'hff9), 2, xv[2], 1);
		xv[3] = xv[1] + xv[2];
		add_row(reg_form(rv_isa_pkg::f7_add, 5'd2, 5'd1, 5'd3), 3, xv[3], 1);
		xv[4] = xv[2] - xv[1];
		add_row(reg_form(rv_isa_pkg::f7_sub, 5'd1, 5'd2, 5'd4), 4, xv[4], 1);
		xv[5] = sext32({20'h80000, 12'h000});
		add_row(upper_form(5'd5, 20'h80000), 5, xv[5], 1);
		xv[6] = xv[5] + sext12(12'h7ff);
		add_row(imm_form(rv_isa_pkg::op_imm, 5'd6, rv_isa_pkg::f3_add, 5'd5, 12'h7ff), 6, xv[6], 1);
		// store then reload the same doubleword
		add_row(store_form(5'd6, 5'd0, 12'd256), 0, '0, 0);
		xv[7] = xv[6];
		add_row(imm_form(rv_isa_pkg::load, 5'd7, rv_isa_pkg::f3_dword, 5'd0, 12'd256), 7, xv[7], 1);
		xv[8] = xv[7] + xv[1];
		add_row(reg_form(rv_isa_pkg::f7_add, 5'd1, 5'd7, 5'd8), 8, xv[8], 1);
		// taken beq and jal each skip one row
		add_row(branch_form(5'd1, 5'd1, 13'd8), 0, '0, 0);
		add_row(imm_form(rv_isa_pkg::op_imm, 5'd9, rv_isa_pkg::f3_add, 5'd0, 12'd1), 9, '0, 0);
		xv[10] = 64'(row_insn.size() * 4) + 64'd4;
		add_row(jump_form(5'd10, 21'd8), 10, xv[10], 1);
		add_row(imm_form(rv_isa_pkg::op_imm, 5'd11, rv_isa_pkg::f3_add, 5'd0, 12'd2), 11, '0, 0);
		xv[12] = xv[3] - xv[4];
		add_row(reg_form(rv_isa_pkg::f7_sub, 5'd4, 5'd3, 5'd12), 12, xv[12], 1);
		// independent addi runs while the load is outstanding
		xv[13] = xv[6];
		add_row(imm_form(rv_isa_pkg::load, 5'd13, rv_isa_pkg::f3_dword, 5'd0, 12'd256), 13, xv[13], 1);
		xv[14] = xv[1] + sext12(12'd1);
		add_row(imm_form(rv_isa_pkg::op_imm, 5'd14, rv_isa_pkg::f3_add, 5'd1, 12'd1), 14, xv[14], 1);
		xv[15] = xv[13] + xv[14];
		add_row(reg_form(rv_isa_pkg::f7_add, 5'd14, 5'd13, 5'd15), 15, xv[15], 1);
		// ebreak
		add_row(imm_form(rv_isa_pkg::system, 5'd0, 3'd0, 5'd0, 12'd1), 0, '0, 0);
	endtask

	// fill pattern and then two instructions per doubleword from address zero
	task automatic load_program();
		int a;
		int i;
		for (a = 0; a < 64; a++)
			mem[a] = {32'(a * 8), ~32'(a * 8)};
		for (i = 0; i < row_insn.size(); i++) begin
			if (i % 2 == 1)
				mem[i / 2][63:32] = row_insn[i];
			else
				mem[i / 2][31:0] = row_insn[i];
			if (row_wr[i]) begin
				exp_wr[row_rd[i]]  = 1'b1;
				exp_val[row_rd[i]] = row_val[i];
			end
		end
	endtask

	// ********************************************************************
	// one clock of the memory model and the retire monitor
	// ********************************************************************
	task automatic step_cycle();
		logic                        s_req;
		logic                        s_write;
		logic [31:0]                 s_addr;
		logic [rv_isa_pkg::xlen-1:0] s_wdata;
		logic [7:0]                  s_strb;
		logic                        s_ret;
		logic [4:0]                  s_rd;
		logic [rv_isa_pkg::xlen-1:0] s_val;
		logic                        s_halt;
		int                          w;
		int                          b;
		// outputs settled mid-cycle
		@(negedge clk);
		s_req   = mem_req_valid;
		s_write = mem_req_write;
		s_addr  = mem_req_addr;
		s_wdata = mem_req_wdata;
		s_strb  = mem_req_strb;
		s_ret   = retire_valid;
		s_rd    = retire_rd;
		s_val   = retire_value;
		s_halt  = halted;
		if (s_req)
			check_flag("request holds a credit", 1'b1, tb_credits != 0);
		// nothing is left to fetch or access once halted is up
		check_flag("request after halt", 1'b0, s_req && s_halt);
		if (s_ret) begin
			check_flag($sformatf("x%0d retire before halt", s_rd), 1'b0, s_halt || halt_seen);
			check_flag($sformatf("x%0d write expected", s_rd), 1'b1, exp_wr[s_rd]);
			check_flag($sformatf("x%0d first write", s_rd), 1'b0, seen[s_rd]);
			check_reg("retire value", s_rd, exp_val[s_rd], s_val);
			seen[s_rd]    = 1'b1;
			ret_cyc[s_rd] = cyc;
		end
		if (s_halt)
			halt_seen = 1'b1;
		@(posedge clk);
		#1;
		cyc++;
		// mirror of the core's credit counter
		tb_credits = tb_credits + (mem_credit ? 1 : 0) - (s_req ? 1 : 0);
		if (s_req) begin
			w = s_addr[8:3];
			rsp_data_q.push_back(mem[w]);
			if (s_write) begin
				for (b = 0; b < 8; b++)
					if (s_strb[b])
						mem[w][8*b +: 8] = s_wdata[8*b +: 8];
			end
			rsp_due_q.push_back(cyc + draw(2));
		end
		// in-order responses at most one per cycle
		mem_rsp_valid = 1'b0;
		mem_rsp_rdata = '0;
		if (rsp_due_q.size() != 0 && rsp_due_q[0] <= cyc) begin
			mem_rsp_valid = 1'b1;
			mem_rsp_rdata = rsp_data_q.pop_front();
			void'(rsp_due_q.pop_front());
			credit_pend++;
		end
		// freed slots come back after a random wait
		mem_credit = 1'b0;
		if (credit_pend != 0 && draw(1) == 1) begin
			mem_credit = 1'b1;
			credit_pend--;
		end
	endtask

	// ********************************************************************
	// main sequence
	// ********************************************************************
	initial begin
		int i;
		int n;
		int r;
		rst           = 1'b1;
		mem_credit    = 1'b0;
		mem_rsp_valid = 1'b0;
		mem_rsp_rdata = '0;
		lfsr          = 32'h32c8f00b;
		tb_credits    = core_bus_pkg::mem_credits;
		credit_pend   = 0;
		cyc           = 0;
		halt_seen     = 1'b0;
		build_program();
		load_program();

		for (i = 0; i < 16; i++) begin
			@(posedge clk);
			#1;
			check_flag("mem_req_valid in reset", 1'b0, mem_req_valid);
			check_flag("retire_valid in reset", 1'b0, retire_valid);
			check_flag("halted in reset", 1'b0, halted);
		end
		rst = 1'b0;
		@(negedge clk);
		check_flag("mem_req_valid after reset", 1'b0, mem_req_valid);
		check_flag("retire_valid after reset", 1'b0, retire_valid);
		check_flag("halted after reset", 1'b0, halted);

		n = 0;
		while (!halt_seen && n < 4000) begin
			step_cycle();
			n++;
		end
		if (!halt_seen) begin
			$display("timeout: the core never raised halted");
			$display("Simulation FAILED");
			$fatal(1);
		end else begin
			// quiet window where nothing may retire after halt
			repeat (40) step_cycle();

			for (r = 1; r < 32; r++)
				if (exp_wr[r])
					check_flag($sformatf("x%0d written", r), 1'b1, seen[r]);
			check_flag("x8 after load x7", 1'b1, ret_cyc[8] > ret_cyc[7]);
			check_flag("x15 after load x13", 1'b1, ret_cyc[15] > ret_cyc[13]);
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule
